//--- source/fifo_width_pkg.sv
`default_nettype none

package fifo_width_pkg;

   // all addresses count bytes
   localparam int byte_w = 8;

   // default fifo geometry
   localparam int def_w_data_w = 32;
   localparam int def_r_data_w = 8;
   localparam int def_addr_w   = 8;

   function automatic int max_w(input int a, input int b);
      if (a > b) begin
         return a;
      end
      return b;
   endfunction

   function automatic int min_w(input int a, input int b);
      if (a < b) begin
         return a;
      end
      return b;
   endfunction

endpackage

`default_nettype wire

//--- source/ram_2p.sv
`default_nettype none

module ram_2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  wire               clk_i,
   input  wire               w_en_i,
   input  wire  [ADDR_W-1:0] w_addr_i,
   input  wire  [DATA_W-1:0] w_data_i,
   input  wire               r_en_i,
   input  wire  [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read port, output holds while r_en_i is low
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

//--- source/ram_2p_asym.sv
`default_nettype none

// byte addressed on both ports, built from N blocks of the narrower width
module ram_2p_asym #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 8
) (
   input  wire                 clk_i,
   input  wire                 w_en_i,
   input  wire  [  ADDR_W-1:0] w_addr_i,
   input  wire  [W_DATA_W-1:0] w_data_i,
   input  wire                 r_en_i,
   input  wire  [  ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o
);

   import fifo_width_pkg::*;

   localparam int MAX_W      = max_w(W_DATA_W, R_DATA_W);
   localparam int BLK_W      = min_w(W_DATA_W, R_DATA_W);
   localparam int N          = MAX_W / BLK_W;
   localparam int SEL_W      = $clog2(N);
   localparam int SYM_W      = $clog2(BLK_W / byte_w);
   localparam int BLK_ADDR_W = ADDR_W - SEL_W - SYM_W;

   logic [    N-1:0] en_wr;
   logic [BLK_W-1:0] data_wr [N];
   logic [BLK_W-1:0] data_rd [N];

   for (genvar i = 0; i < N; i++) begin : g_blk
      ram_2p #(
         .DATA_W(BLK_W),
         .ADDR_W(BLK_ADDR_W)
      ) u_blk (
         .clk_i   (clk_i),
         .w_en_i  (en_wr[i]),
         .w_addr_i(w_addr_i[ADDR_W-1:SEL_W+SYM_W]),
         .w_data_i(data_wr[i]),
         .r_en_i  (r_en_i),
         .r_addr_i(r_addr_i[ADDR_W-1:SEL_W+SYM_W]),
         .r_data_o(data_rd[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_w
      logic [SEL_W-1:0] r_sel;

      // every block takes its own slice, lowest bytes in block 0
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en_i;
            data_wr[j] = w_data_i[j*BLK_W+:BLK_W];
         end
      end

      // select follows the data register of the blocks
      always_ff @(posedge clk_i) begin
         if (r_en_i) begin
            r_sel <= r_addr_i[SYM_W+:SEL_W];
         end
      end

      assign r_data_o = data_rd[r_sel];
   end else if (W_DATA_W < R_DATA_W) begin : g_wide_r
      // narrow write goes to one block only
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = w_en_i && (w_addr_i[SYM_W+:SEL_W] == SEL_W'(j));
            data_wr[j] = w_data_i;
         end
      end

      always_comb begin
         for (int k = 0; k < N; k++) begin
            r_data_o[k*BLK_W+:BLK_W] = data_rd[k];
         end
      end
   end else begin : g_equal
      assign en_wr[0]   = w_en_i;
      assign data_wr[0] = w_data_i;
      assign r_data_o   = data_rd[0];
   end

   initial begin
      assert (ADDR_W > SEL_W + SYM_W)
      else $error("ADDR_W too small for %0d blocks of %0d bits", N, BLK_W);
      assert (MAX_W % BLK_W == 0)
      else $error("width %0d is not a multiple of %0d", MAX_W, BLK_W);
   end

   a_w_addr_known : assert property (@(posedge clk_i) w_en_i |-> !$isunknown(w_addr_i));
   a_r_addr_known : assert property (@(posedge clk_i) r_en_i |-> !$isunknown(r_addr_i));

endmodule

`default_nettype wire

//--- source/fifo_width_ctrl.sv
`default_nettype none

module fifo_width_ctrl #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 8
) (
   input  wire                clk_i,
   input  wire                arst_n_i,
   input  wire                w_en_i,
   input  wire                r_en_i,
   output logic               ram_w_en_o,
   output logic [ADDR_W-1:0]  ram_w_addr_o,
   output logic               ram_r_en_o,
   output logic [ADDR_W-1:0]  ram_r_addr_o,
   output logic               full_o,
   output logic               empty_o,
   output logic [  ADDR_W:0]  level_o,
   output logic               r_valid_o
);

   import fifo_width_pkg::*;

   // bytes moved per access and total depth
   localparam logic [ADDR_W:0] W_BYTES = (ADDR_W + 1)'(W_DATA_W / byte_w);
   localparam logic [ADDR_W:0] R_BYTES = (ADDR_W + 1)'(R_DATA_W / byte_w);
   localparam logic [ADDR_W:0] DEPTH   = (ADDR_W + 1)'(2 ** ADDR_W);

   // extra msb tells full from empty
   logic [ADDR_W:0] w_ptr;
   logic [ADDR_W:0] r_ptr;
   logic [ADDR_W:0] level;
   logic [ADDR_W:0] free;
   logic            w_acc;
   logic            r_acc;

   assign level = w_ptr - r_ptr;
   assign free  = DEPTH - level;

   assign full_o  = free < W_BYTES;
   assign empty_o = level < R_BYTES;
   assign level_o = level;

   assign w_acc = w_en_i && !full_o;
   assign r_acc = r_en_i && !empty_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_ptr <= '0;
      end else if (w_acc) begin
         w_ptr <= w_ptr + W_BYTES;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_ptr <= '0;
      end else if (r_acc) begin
         r_ptr <= r_ptr + R_BYTES;
      end
   end

   // ram read data shows up one clock after the accepted read
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_valid_o <= 1'b0;
      end else begin
         r_valid_o <= r_acc;
      end
   end

   assign ram_w_en_o   = w_acc;
   assign ram_w_addr_o = w_ptr[ADDR_W-1:0];
   assign ram_r_en_o   = r_acc;
   assign ram_r_addr_o = r_ptr[ADDR_W-1:0];

   // an overrun or an underrun pushes the pointer distance past the depth
   a_level_max : assert property (
      @(posedge clk_i) disable iff (!arst_n_i) level_o <= DEPTH);

endmodule

`default_nettype wire

//--- source/fifo_width_top.sv
`default_nettype none

module fifo_width_top #(
   parameter int W_DATA_W = fifo_width_pkg::def_w_data_w,
   parameter int R_DATA_W = fifo_width_pkg::def_r_data_w,
   parameter int ADDR_W   = fifo_width_pkg::def_addr_w
) (
   input  wire                 clk_i,
   input  wire                 arst_n_i,
   input  wire                 w_en_i,
   input  wire  [W_DATA_W-1:0] w_data_i,
   input  wire                 r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_valid_o,
   output logic                full_o,
   output logic                empty_o,
   output logic [    ADDR_W:0] level_o
);

   // byte addresses from controller to ram
   logic              ram_w_en;
   logic [ADDR_W-1:0] ram_w_addr;
   logic              ram_r_en;
   logic [ADDR_W-1:0] ram_r_addr;

   fifo_width_ctrl #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_ctrl (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .w_en_i      (w_en_i),
      .r_en_i      (r_en_i),
      .ram_w_en_o  (ram_w_en),
      .ram_w_addr_o(ram_w_addr),
      .ram_r_en_o  (ram_r_en),
      .ram_r_addr_o(ram_r_addr),
      .full_o      (full_o),
      .empty_o     (empty_o),
      .level_o     (level_o),
      .r_valid_o   (r_valid_o)
   );

   ram_2p_asym #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (ram_w_en),
      .w_addr_i(ram_w_addr),
      .w_data_i(w_data_i),
      .r_en_i  (ram_r_en),
      .r_addr_i(ram_r_addr),
      .r_data_o(r_data_o)
   );

endmodule

`default_nettype wire

//--- dv/tb_fifo_width.sv
`default_nettype none

module tb_fifo_width;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int W_DATA_W   = 32;
   localparam int R_DATA_W   = 8;
   localparam int ADDR_W     = 8;
   localparam int DEPTH      = 2 ** ADDR_W;
   localparam int W_BYTES    = W_DATA_W / 8;
   localparam int CLK_PERIOD = 10;
   localparam int RST_CYC    = 16;
   localparam int FILL_CYC   = DEPTH / W_BYTES + 8;
   localparam int DRAIN_CYC  = DEPTH + 8;
   localparam int RAND_CYC   = 2000;
   localparam int MARGIN_CYC = 200;
   localparam int RUN_CYC    = RST_CYC + FILL_CYC + DRAIN_CYC + RAND_CYC + DRAIN_CYC
                               + MARGIN_CYC;

   logic                clk_i = 1'b0;
   logic                arst_n_i;
   logic                w_en_i;
   logic [W_DATA_W-1:0] w_data_i;
   logic                r_en_i;
   logic [R_DATA_W-1:0] r_data_o;
   logic                r_valid_o;
   logic                full_o;
   logic                empty_o;
   logic [  ADDR_W:0]   level_o;

   // reference model state
   logic [7:0]      byte_q [$];
   logic [7:0]      popped;
   logic [7:0]      exp_byte;
   logic            exp_valid;
   logic [ADDR_W:0] model_len;
   bit              w_acc;
   bit              r_acc;
   int              cnt_full_w;
   int              cnt_empty_r;
   int              cnt_both;
   int              cnt_rd;

   logic [15:0] lfsr_state = 16'd29895;

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   fifo_width_top #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_dut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_valid_o(r_valid_o),
      .full_o   (full_o),
      .empty_o  (empty_o),
      .level_o  (level_o)
   );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "run aborted");
   endtask

   // byte queue, wide words go in lowest byte first
   always @(posedge clk_i) begin
      if (!arst_n_i) begin
         byte_q.delete();
         model_len <= '0;
         exp_valid <= 1'b0;
         exp_byte  <= '0;
      end else begin
         w_acc = w_en_i && (byte_q.size() <= DEPTH - W_BYTES);
         r_acc = r_en_i && (byte_q.size() > 0);
         if (r_acc) begin
            popped = byte_q.pop_front();
            exp_byte <= popped;
            cnt_rd++;
         end else if (r_en_i) begin
            cnt_empty_r++;
         end
         if (w_acc) begin
            for (int b = 0; b < W_BYTES; b++) begin
               byte_q.push_back(w_data_i[8*b+:8]);
            end
         end else if (w_en_i) begin
            cnt_full_w++;
         end
         if (w_acc && r_acc) begin
            cnt_both++;
         end
         exp_valid <= r_acc;
         model_len <= (ADDR_W + 1)'(byte_q.size());
      end
   end

   a_reset_state : assert property (@(posedge clk_i)
      $rose(arst_n_i) |-> empty_o && !full_o && level_o == '0 && !r_valid_o)
   else abort_run("outputs were not in their reset state when reset was released");

   a_read_data : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_valid_o |-> r_data_o == exp_byte)
   else report_mismatch("r_data_o", 32'($sampled(exp_byte)), 32'($sampled(r_data_o)));

   // one valid per accepted read, one cycle later
   a_read_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      r_valid_o == exp_valid)
   else report_mismatch("r_valid_o", 32'($sampled(exp_valid)), 32'($sampled(r_valid_o)));

   a_level : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      level_o == model_len)
   else report_mismatch("level_o", 32'($sampled(model_len)), 32'($sampled(level_o)));

   a_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      full_o == (model_len > (ADDR_W + 1)'(DEPTH - W_BYTES)))
   else report_mismatch("full_o", 32'($sampled(model_len) > (ADDR_W + 1)'(DEPTH - W_BYTES)),
                        32'($sampled(full_o)));

   a_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      empty_o == (model_len == '0))
   else report_mismatch("empty_o", 32'($sampled(model_len) == '0), 32'($sampled(empty_o)));

   a_full_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      full_o && w_en_i && !r_en_i |=> $stable(level_o))
   else abort_run("a write strobed while full changed the fill level");

   a_empty_read : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      empty_o && r_en_i |=> !r_valid_o)
   else abort_run("a read strobed while empty produced r_valid_o");

   initial begin
      #(RUN_CYC * CLK_PERIOD);
      abort_run($sformatf("watchdog expired after %0d cycles", RUN_CYC));
   end

   initial begin
      logic [31:0] v;
      arst_n_i = 1'b0;
      w_en_i   = 1'b0;
      r_en_i   = 1'b0;
      w_data_i = '0;
      repeat (RST_CYC) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(posedge clk_i);

      // fill, then keep pushing against full
      while (!full_o) begin
         draw_bits(32, v);
         w_data_i <= v;
         w_en_i   <= 1'b1;
         @(posedge clk_i);
      end
      repeat (3) begin
         draw_bits(32, v);
         w_data_i <= v;
         @(posedge clk_i);
      end

      // drain, then keep reading against empty
      w_en_i <= 1'b0;
      r_en_i <= 1'b1;
      while (!empty_o) @(posedge clk_i);
      repeat (3) @(posedge clk_i);
      r_en_i <= 1'b0;

      // about one byte in per cycle, 0.75 out
      repeat (RAND_CYC) begin
         draw_bits(2, v);
         w_en_i <= &v[1:0];
         draw_bits(2, v);
         r_en_i <= |v[1:0];
         draw_bits(32, v);
         w_data_i <= v;
         @(posedge clk_i);
      end

      w_en_i <= 1'b0;
      r_en_i <= 1'b1;
      @(posedge clk_i);
      while (!empty_o) @(posedge clk_i);
      r_en_i <= 1'b0;
      repeat (4) @(posedge clk_i);

      // more reads than bytes of depth means the pointers wrapped
      if (cnt_full_w == 0 || cnt_empty_r == 0 || cnt_both == 0 || cnt_rd <= DEPTH) begin
         abort_run($sformatf("behavior not reached: full writes %0d, empty reads %0d, %s %0d, %s %0d",
                             cnt_full_w, cnt_empty_r, "overlaps", cnt_both, "reads", cnt_rd));
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- list.f
source/fifo_width_pkg.sv
source/ram_2p.sv
source/ram_2p_asym.sv
source/fifo_width_ctrl.sv
source/fifo_width_top.sv
dv/tb_fifo_width.sv

//--- run_sim.sh
#!/bin/sh
# builds the fifo testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
   --top-module tb_fifo_width \
   -f list.f \
   -o sim_fifo_width
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/sim_fifo_width)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF "Simulation finished: PASS"; then
   exit 0
fi

echo "pass line not found in simulation output"
exit 1
